// ==== Makefile ====
TOP = hist_builder_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hist_bin_memory.sv ====
`timescale 1ns/100ps

`include "hist_macros.svh"

module hist_bin_memory (
    input  logic                   clk,
    input  logic                   combin_res,
    input  hist_pkg::hist_event_t  tagged_event,
    output hist_pkg::hist_update_t update
);

    // counter storage with one word per pixel and bin
    logic [`COUNT_W-1:0] bin_mem [`BIN_TOTAL];

    // per-bin valid flag
    // a cleared flag reads as an empty counter
    logic [`BIN_TOTAL-1:0] bin_valid;

    // flat address with the pixel in the upper bits
    logic [`PIX_W+`NB-1:0] addr;
    logic [`COUNT_W-1:0]   cur_count;
    logic [`COUNT_W-1:0]   next_count;

    always_comb begin
        addr = {tagged_event.pixel, tagged_event.bin};
        // stale words behind a cleared flag count as zero
        if (bin_valid[addr]) begin
            cur_count = bin_mem[addr];
        end else begin
            cur_count = '0;
        end
        next_count = cur_count + 1'b1;
    end

    // write back the incremented count
    always_ff @(posedge clk) begin
        if (tagged_event.valid) begin
            bin_mem[addr] <= next_count;
        end
    end

    // flag handling
    // the clear on the final event wins over the set
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            bin_valid <= '0;
        end else if (tagged_event.valid) begin
            if (tagged_event.last) begin
                // whole acquisition dropped in one cycle
                bin_valid <= '0;
            end else begin
                bin_valid[addr] <= 1'b1;
            end
        end
    end

    // registered increment result one cycle after the strobe
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            update <= '0;
        end else begin
            update.valid <= tagged_event.valid;
            update.pixel <= tagged_event.pixel;
            update.bin   <= tagged_event.bin;
            update.count <= next_count;
            update.last  <= tagged_event.last;
        end
    end

    // every tagged strobe yields one update on the next cycle
    // a zero count there means the counter wrapped
    a_update_follows : assert property (
        @(posedge clk) disable iff (!combin_res)
        tagged_event.valid |=> update.valid && update.count != '0
    );

endmodule

// ==== hist_builder_tb.sv ====
`timescale 1ns/100ps

`include "hist_macros.svh"

module hist_builder_tb;

    logic                   clk;
    logic                   combin_res;
    logic                   wr_en;
    logic [`NB-1:0]         bin;
    hist_pkg::hist_update_t update;
    hist_pkg::peak_table_t  peak_table;
    logic                   peak_done;
    logic                   hist_bank;

    // reference model state
    int model_cnt [`PIXEL_NUM][1 << `NB];
    int max_cnt [`PIXEL_NUM];
    int max_bin [`PIXEL_NUM];
    int ev_pos;
    int pix_pos;
    int frame_pos;

    // expected outputs, one and two cycles behind the drive
    hist_pkg::hist_update_t p1_upd;
    hist_pkg::peak_table_t  p1_table;
    logic                   p2_last;
    hist_pkg::peak_table_t  p2_table;
    hist_pkg::hist_update_t exp_upd;
    logic                   exp_done;
    hist_pkg::peak_table_t  held_table;
    logic                   held_bank;

    hist_builder_top hist_builder_top_i (
        .clk        (clk),
        .combin_res (combin_res),
        .wr_en      (wr_en),
        .bin        (bin),
        .update     (update),
        .peak_table (peak_table),
        .peak_done  (peak_done),
        .hist_bank  (hist_bank)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string text);
        $display("%s", text);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // new acquisition, every bin back to empty
    task automatic clear_model();
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            for (int b = 0; b < (1 << `NB); b++) begin
                model_cnt[p][b] = 0;
            end
            max_cnt[p] = 0;
            max_bin[p] = 0;
        end
    endtask

    // one event through the scan order, counters and peak rule
    task automatic model_event(input logic en, input logic [`NB-1:0] b,
                               output hist_pkg::hist_update_t upd,
                               output hist_pkg::peak_table_t tbl);
        int c;
        upd = '0;
        tbl = '0;
        if (en) begin
            c = model_cnt[pix_pos][b] + 1;
            model_cnt[pix_pos][b] = c;
            upd.valid = 1'b1;
            upd.pixel = `PIX_W'(pix_pos);
            upd.bin   = b;
            upd.count = `COUNT_W'(c);
            upd.last  = (ev_pos == `DATA_NUM - 1) && (pix_pos == `PIXEL_NUM - 1)
                        && (frame_pos == `ACQ_NUM - 1);
            // strictly greater, so the earliest bin keeps a tie
            if (c > max_cnt[pix_pos]) begin
                max_cnt[pix_pos] = c;
                max_bin[pix_pos] = int'(b);
            end
            if (upd.last) begin
                for (int p = 0; p < `PIXEL_NUM; p++) begin
                    tbl[p] = `NB'(max_bin[p]);
                end
                clear_model();
            end
            ev_pos++;
            if (ev_pos == `DATA_NUM) begin
                ev_pos = 0;
                pix_pos++;
                if (pix_pos == `PIXEL_NUM) begin
                    pix_pos = 0;
                    frame_pos = (frame_pos == `ACQ_NUM - 1) ? 0 : frame_pos + 1;
                end
            end
        end
    endtask

    task automatic check_outputs();
        assert (update.valid == exp_upd.valid) else abort_run($sformatf(
            "ERROR at %0t: update.valid is %0b, expected %0b", $time, update.valid,
            exp_upd.valid));
        if (exp_upd.valid) begin
            assert (update.pixel == exp_upd.pixel && update.bin == exp_upd.bin
                    && update.last == exp_upd.last) else abort_run($sformatf(
                "ERROR at %0t: update position %0d/%0d/%0b, expected %0d/%0d/%0b", $time,
                update.pixel, update.bin, update.last, exp_upd.pixel, exp_upd.bin,
                exp_upd.last));
            assert (update.count == exp_upd.count) else abort_run($sformatf(
                "ERROR at %0t: update.count is %0d, expected %0d", $time, update.count,
                exp_upd.count));
        end
        assert (peak_done == exp_done) else abort_run($sformatf(
            "ERROR at %0t: peak_done is %0b, expected %0b", $time, peak_done, exp_done));
        assert (peak_table == held_table) else abort_run($sformatf(
            "ERROR at %0t: peak_table is %h, expected %h", $time, peak_table, held_table));
        assert (hist_bank == held_bank) else abort_run($sformatf(
            "ERROR at %0t: hist_bank is %0b, expected %0b", $time, hist_bank, held_bank));
    endtask

    // drive on the rising edge, compare on the falling one
    task automatic step_cycle(input logic force_en);
        logic           en;
        logic [`NB-1:0] b;
        @(posedge clk);
        en = force_en || (($urandom % 10) < 7);
        b  = `NB'($urandom);
        wr_en <= en;
        bin   <= b;
        // what the DUT shows after this edge
        exp_upd  = p1_upd;
        exp_done = p2_last;
        if (p2_last) begin
            held_table = p2_table;
            held_bank  = ~held_bank;
        end
        p2_last  = p1_upd.valid && p1_upd.last;
        p2_table = p1_table;
        model_event(en, b, p1_upd, p1_table);
        @(negedge clk);
        check_outputs();
    endtask

    initial begin
        int waited;
        combin_res = 1'b0;
        wr_en      = 1'b0;
        bin        = '0;
        p1_upd     = '0;
        p1_table   = '0;
        p2_last    = 1'b0;
        p2_table   = '0;
        exp_upd    = '0;
        exp_done   = 1'b0;
        held_table = '0;
        held_bank  = 1'b0;
        ev_pos     = 0;
        pix_pos    = 0;
        frame_pos  = 0;
        clear_model();
        void'($urandom(32'ha12b4509));
        repeat (5) @(posedge clk);
        combin_res <= 1'b1;
        // reset values before the first strobe
        @(negedge clk);
        check_outputs();
        for (int acq = 0; acq < 4; acq++) begin
            waited = 0;
            do begin
                // strobe forced right after a last event
                step_cycle(p1_upd.valid && p1_upd.last);
                waited++;
                if (waited > 400) begin
                    abort_run($sformatf("timeout: no peak_done seen in acquisition %0d", acq));
                end
            end while (!peak_done);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== hist_builder_top.sv ====
`timescale 1ns/100ps

`include "hist_macros.svh"

module hist_builder_top (
    input  logic                   clk,
    input  logic                   combin_res,
    input  logic                   wr_en,
    input  logic [`NB-1:0]         bin,
    output hist_pkg::hist_update_t update,
    output hist_pkg::peak_table_t  peak_table,
    output logic                   peak_done,
    output logic                   hist_bank
);

    // strobe tagged with pixel and last flag
    hist_pkg::hist_event_t tagged_event;

    // scan position
    hist_scan_counter hist_scan_counter_i (
        .clk          (clk),
        .combin_res   (combin_res),
        .wr_en        (wr_en),
        .bin          (bin),
        .tagged_event (tagged_event)
    );

    // shared bin memory
    hist_bin_memory hist_bin_memory_i (
        .clk          (clk),
        .combin_res   (combin_res),
        .tagged_event (tagged_event),
        .update       (update)
    );

    // peaks from the update stream
    hist_peak_tracker hist_peak_tracker_i (
        .clk        (clk),
        .combin_res (combin_res),
        .update     (update),
        .peak_table (peak_table),
        .peak_done  (peak_done),
        .hist_bank  (hist_bank)
    );

endmodule

// ==== hist_macros.svh ====
`ifndef HIST_MACROS_SVH
`define HIST_MACROS_SVH

// bin address width per pixel, 16 bins
`define NB 4

// events per pixel in one frame
`define DATA_NUM 4

// pixels in one frame
`define PIXEL_NUM 4

// pixel index width, covers PIXEL_NUM
`define PIX_W 2

// frames per acquisition
`define ACQ_NUM 3

// bin count width
// must hold DATA_NUM * ACQ_NUM in the worst case
`define COUNT_W 8

// total bins in the shared memory
`define BIN_TOTAL (`PIXEL_NUM * (1 << `NB))

`endif

// ==== hist_peak_tracker.sv ====
`timescale 1ns/100ps

`include "hist_macros.svh"

module hist_peak_tracker (
    input  logic                   clk,
    input  logic                   combin_res,
    input  hist_pkg::hist_update_t update,
    output hist_pkg::peak_table_t  peak_table,
    output logic                   peak_done,
    output logic                   hist_bank
);

    // running maximum per pixel
    logic [`PIXEL_NUM-1:0][`COUNT_W-1:0] max_count;
    // bin that first reached the maximum
    hist_pkg::peak_table_t               max_bin;

    // strict compare keeps the earliest bin on a tie
    logic                  upd_greater;
    // bins with the current update folded in
    hist_pkg::peak_table_t folded_bins;
    logic                  acq_close;

    always_comb begin
        upd_greater = update.valid && (update.count > max_count[update.pixel]);
        acq_close   = update.valid && update.last;
        folded_bins = max_bin;
        if (upd_greater) begin
            folded_bins[update.pixel] = update.bin;
        end
    end

    // peak bins
    // each pixel sees events every frame, so its first update
    // of an acquisition always replaces whatever is left here
    always_ff @(posedge clk) begin
        if (upd_greater) begin
            max_bin[update.pixel] <= update.bin;
        end
    end

    // maxima, zeroed at the end of each acquisition
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            max_count <= '0;
        end else if (acq_close) begin
            max_count <= '0;
        end else if (upd_greater) begin
            max_count[update.pixel] <= update.count;
        end
    end

    // publication, done pulse and bank toggle
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            peak_table <= '0;
            peak_done  <= 1'b0;
            hist_bank  <= 1'b0;
        end else begin
            peak_done <= acq_close;
            if (acq_close) begin
                // includes the final update of the acquisition
                peak_table <= folded_bins;
                hist_bank  <= ~hist_bank;
            end
        end
    end

    // one pulse per acquisition, never stretched
    a_done_single : assert property (
        @(posedge clk) disable iff (!combin_res)
        peak_done |=> !peak_done
    );

endmodule

// ==== hist_pkg.sv ====
`include "hist_macros.svh"

package hist_pkg;

    // one strobe tagged with its scan position
    typedef struct packed {
        logic              valid;
        logic [`PIX_W-1:0] pixel;
        logic [`NB-1:0]    bin;
        // final event of the acquisition
        logic              last;
    } hist_event_t;

    // registered result of one increment
    typedef struct packed {
        logic                valid;
        logic [`PIX_W-1:0]   pixel;
        logic [`NB-1:0]      bin;
        // count after this event
        logic [`COUNT_W-1:0] count;
        logic                last;
    } hist_update_t;

    // peak bin of every pixel, entry index is the pixel
    typedef logic [`PIXEL_NUM-1:0][`NB-1:0] peak_table_t;

endpackage

// ==== hist_scan_counter.sv ====
`timescale 1ns/100ps

`include "hist_macros.svh"

module hist_scan_counter (
    input  logic                  clk,
    input  logic                  combin_res,
    input  logic                  wr_en,
    input  logic [`NB-1:0]        bin,
    output hist_pkg::hist_event_t tagged_event
);

    // position inside the scan order
    logic [$clog2(`DATA_NUM)-1:0] event_cnt;
    logic [`PIX_W-1:0]            pixel_cnt;
    logic [$clog2(`ACQ_NUM)-1:0]  frame_cnt;

    // wrap conditions chained from the innermost counter
    logic pixel_end;
    logic frame_end;
    logic acq_end;

    always_comb begin
        pixel_end = (int'(event_cnt) == `DATA_NUM - 1);
        frame_end = pixel_end && (int'(pixel_cnt) == `PIXEL_NUM - 1);
        acq_end   = frame_end && (int'(frame_cnt) == `ACQ_NUM - 1);
    end

    // tag is combinational in the same cycle as the strobe
    always_comb begin
        tagged_event.valid = wr_en;
        tagged_event.pixel = pixel_cnt;
        tagged_event.bin   = bin;
        // only a real strobe can close the acquisition
        tagged_event.last  = wr_en && acq_end;
    end

    // counters move only on accepted strobes
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            event_cnt <= '0;
            pixel_cnt <= '0;
            frame_cnt <= '0;
        end else if (wr_en) begin
            if (pixel_end) begin
                event_cnt <= '0;
            end else begin
                event_cnt <= event_cnt + 1'b1;
            end
            // next pixel after DATA_NUM events
            if (pixel_end) begin
                if (frame_end) begin
                    pixel_cnt <= '0;
                end else begin
                    pixel_cnt <= pixel_cnt + 1'b1;
                end
            end
            // next frame after the last pixel
            if (frame_end) begin
                if (acq_end) begin
                    frame_cnt <= '0;
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
        end
    end

    // pixel and frame indices must wrap before running past their limits
    a_scan_in_range : assert property (
        @(posedge clk) disable iff (!combin_res)
        int'(pixel_cnt) < `PIXEL_NUM && int'(frame_cnt) < `ACQ_NUM
    );

endmodule

// ==== project.f ====
+incdir+.
hist_pkg.sv
hist_scan_counter.sv
hist_bin_memory.sv
hist_peak_tracker.sv
hist_builder_top.sv
hist_builder_tb.sv
